/* verilog/pcpu_pkg.sv */
// Shared definitions for the 16-bit five-stage pipelined processor.
// Opcodes, instruction field positions, widths and the register write classes.
package pcpu_pkg;

    localparam int DATA_W    = 16;
    localparam int ADDR_W    = 8;
    localparam int REG_SEL_W = 3;

    // Instruction fields
    localparam int OP_HI   = 15;
    localparam int OP_LO   = 11;
    localparam int R1_HI   = 10;
    localparam int R1_LO   = 8;
    localparam int R2_HI   = 6;
    localparam int R2_LO   = 4;
    localparam int R3_HI   = 2;
    localparam int R3_LO   = 0;
    localparam int IMM8_HI = 7;
    localparam int IMM8_LO = 0;
    localparam int IMM4_HI = 3;
    localparam int IMM4_LO = 0;

    localparam logic [DATA_W-1:0] NOP_WORD = '0;

    typedef enum logic [4:0] {
        NOP  = 5'b00000, HALT = 5'b00001, LOAD = 5'b00010, STORE = 5'b00011,
        SLL  = 5'b00100, SRL  = 5'b00101, ADD  = 5'b01000, ADDI  = 5'b01001,
        SUB  = 5'b01010, SUBI = 5'b01011, CMP  = 5'b01100, AND   = 5'b01101,
        OR   = 5'b01110, XOR  = 5'b01111, LDIH = 5'b10000, JUMP  = 5'b11000,
        JMPR = 5'b11001, BZ   = 5'b11010, BNZ  = 5'b11011, BN    = 5'b11100,
        BNN  = 5'b11101, BC   = 5'b11110, BNC  = 5'b11111
    } opcode_t;

    typedef enum logic {IDLE = 1'b0, EXEC = 1'b1} run_state_t;

    // ALU results that can be forwarded to decode
    function automatic logic is_arith(opcode_t op);
        case (op)
            LDIH, ADD, ADDI, SUB, SUBI, AND, OR, XOR, SLL, SRL: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic writes_register(opcode_t op);
        return is_arith(op) || (op == LOAD);
    endfunction

endpackage

/* verilog/operand_if.sv */
// Forwarding sources and register file read ports shared between stages.
// Decode reads the sources, execute and writeback drive them.
`timescale 1ns/1ps

interface operand_if import pcpu_pkg::*; #(parameter int DATA_W = 16);

    logic [DATA_W-1:0]    ex_result, mem_result, wb_result;
    logic [REG_SEL_W-1:0] ex_dest, mem_dest, wb_dest;
    logic                 ex_fwd, mem_fwd, mem_is_load, wb_fwd;
    logic [REG_SEL_W-1:0] rd_sel_a, rd_sel_b;
    logic [DATA_W-1:0]    rd_data_a, rd_data_b;

    modport decode (
        input  ex_result, ex_dest, ex_fwd,
        input  mem_result, mem_dest, mem_fwd, mem_is_load,
        input  wb_result, wb_dest, wb_fwd,
        input  rd_data_a, rd_data_b,
        output rd_sel_a, rd_sel_b
    );

    modport execute (
        output ex_result, ex_dest, ex_fwd,
        output mem_result, mem_dest, mem_fwd, mem_is_load
    );

    modport regfile (
        output wb_result, wb_dest, wb_fwd, rd_data_a, rd_data_b,
        input  rd_sel_a, rd_sel_b
    );

endinterface

/* verilog/run_control.sv */
// Run/idle control of the pipeline.
// Starts on enable with start, stops on a retiring HALT or when enable drops.
`timescale 1ns/1ps

module run_control import pcpu_pkg::*; (
    input  logic clock,
    input  logic reset,
    input  logic enable,
    input  logic start,
    input  logic halt_retire,
    output logic run
);

    run_state_t state, next_state;

    always_ff @(posedge clock or negedge reset)
    begin
        if (!reset)
            state <= IDLE;
        else
            state <= next_state;
    end

    always_comb
    begin
        case (state)
            IDLE:    next_state = (enable && start) ? EXEC : IDLE;
            EXEC:    next_state = (!enable || halt_retire) ? IDLE : EXEC;
            default: next_state = IDLE;
        endcase
    end

    assign run = (state == EXEC);    // Gates every stage register

endmodule

/* verilog/fetch_decode.sv */
// Fetch and decode stages: program counter, decode instruction register,
// load stall and operand selection with forwarding from the later stages.
`timescale 1ns/1ps

module fetch_decode import pcpu_pkg::*; #(
    parameter int DATA_W = 16,
    parameter int ADDR_W = 8
) (
    input  logic              clock,
    input  logic              reset,
    input  logic              run,
    input  logic              flush,
    input  logic [ADDR_W-1:0] branch_target,
    output logic [ADDR_W-1:0] pc,
    input  logic [DATA_W-1:0] i_datain,
    output logic [DATA_W-1:0] ex_ir,
    output logic [DATA_W-1:0] reg_a,
    output logic [DATA_W-1:0] reg_b,
    output logic [DATA_W-1:0] store_data,
    operand_if.decode         ops
);

    logic [DATA_W-1:0]    id_ir;
    opcode_t              id_op;
    logic [REG_SEL_W-1:0] sel_a, sel_b;
    logic [DATA_W-1:0]    opnd_a, opnd_b;
    logic [DATA_W-1:0]    imm4, imm8;
    logic [DATA_W-1:0]    next_a, next_b;

    assign id_op = opcode_t'(id_ir[OP_HI:OP_LO]);
    assign imm4  = DATA_W'(id_ir[IMM4_HI:IMM4_LO]);
    assign imm8  = DATA_W'(id_ir[IMM8_HI:IMM8_LO]);

    // Youngest producer wins, r0 is never forwarded
    function automatic logic [DATA_W-1:0] pick(input logic [REG_SEL_W-1:0] sel,
                                              input logic [DATA_W-1:0]    rf_data);
        if (sel == '0)
            return rf_data;
        if (ops.ex_fwd && (ops.ex_dest == sel))
            return ops.ex_result;
        if ((ops.mem_fwd || ops.mem_is_load) && (ops.mem_dest == sel))
            return ops.mem_result;                  // ALU result or load data
        if (ops.wb_fwd && (ops.wb_dest == sel))
            return ops.wb_result;
        return rf_data;
    endfunction

    // Source register numbers
    always_comb
    begin
        sel_a = id_ir[R2_HI:R2_LO];
        sel_b = id_ir[R3_HI:R3_LO];
        case (id_op)
            ADDI, SUBI, JMPR, BZ, BNZ, BN, BNN, BC, BNC:
                sel_a = id_ir[R1_HI:R1_LO];         // r1 is base or source
            STORE:
                sel_b = id_ir[R1_HI:R1_LO];         // Store data from r1
            default: ;
        endcase
    end

    assign ops.rd_sel_a = sel_a;
    assign ops.rd_sel_b = sel_b;

    always_comb
    begin
        opnd_a = pick(sel_a, ops.rd_data_a);
        opnd_b = pick(sel_b, ops.rd_data_b);
        case (id_op)
            LOAD, STORE, SLL, SRL:
            begin
                next_a = opnd_a;
                next_b = imm4;
            end
            ADD, SUB, CMP, AND, OR, XOR:
            begin
                next_a = opnd_a;
                next_b = opnd_b;
            end
            ADDI, SUBI, JMPR, BZ, BNZ, BN, BNN, BC, BNC:
            begin
                next_a = opnd_a;
                next_b = imm8;
            end
            LDIH, JUMP:
            begin
                next_a = '0;
                next_b = imm8;
            end
            default:
            begin
                next_a = '0;                        // NOP and HALT
                next_b = '0;
            end
        endcase
    end

    always_ff @(posedge clock or negedge reset)
    begin
        if (!reset)
        begin
            pc         <= '0;
            id_ir      <= NOP_WORD;
            ex_ir      <= NOP_WORD;
            reg_a      <= '0;
            reg_b      <= '0;
            store_data <= '0;
        end
        else if (run)
        begin
            if (flush)
            begin
                pc    <= branch_target;
                id_ir <= NOP_WORD;
            end
            else if (id_op == LOAD)
                id_ir <= NOP_WORD;                  // One bubble, pc holds
            else
            begin
                pc    <= pc + 1'b1;
                id_ir <= i_datain;
            end
            ex_ir      <= flush ? NOP_WORD : id_ir;
            reg_a      <= next_a;
            reg_b      <= next_b;
            store_data <= opnd_b;
        end
    end

endmodule

/* verilog/alu.sv */
// Combinational ALU of the execute stage.
// The top result bit is the carry of an add or the borrow of a subtract.
`timescale 1ns/1ps

module alu import pcpu_pkg::*; #(
    parameter int DATA_W = 16
) (
    input  opcode_t           op,
    input  logic [DATA_W-1:0] a,
    input  logic [DATA_W-1:0] b,
    output logic [DATA_W:0]   result
);

    always_comb
    begin
        result = '0;
        case (op)
            // Address arithmetic shares the adder
            ADD, ADDI, LOAD, STORE, JMPR, BZ, BNZ, BN, BNN, BC, BNC:
                result = {1'b0, a} + {1'b0, b};
            SUB, SUBI, CMP:
                result = {1'b0, a} - {1'b0, b};
            AND:
                result = {1'b0, a & b};
            OR:
                result = {1'b0, a | b};
            XOR:
                result = {1'b0, a ^ b};
            SLL:
                result = {1'b0, a << b};
            SRL:
                result = {1'b0, a >> b};
            LDIH:
                result[DATA_W-1 -: 8] = b[IMM8_HI:IMM8_LO];  // Low byte to high byte
            JUMP:
                result[IMM8_HI:IMM8_LO] = b[IMM8_HI:IMM8_LO];
            default: ;                                  // NOP, HALT
        endcase
    end

endmodule

/* verilog/execute_stage.sv */
// Execute stage: ALU, flags, store strobe and the memory-stage branch decision.
// A taken jump or branch in the memory stage flushes the younger stages.
`timescale 1ns/1ps

module execute_stage import pcpu_pkg::*; #(
    parameter int DATA_W = 16,
    parameter int ADDR_W = 8
) (
    input  logic              clock,
    input  logic              reset,
    input  logic              run,
    input  logic [DATA_W-1:0] ex_ir,
    input  logic [DATA_W-1:0] reg_a,
    input  logic [DATA_W-1:0] reg_b,
    input  logic [DATA_W-1:0] store_data,
    input  logic [DATA_W-1:0] d_datain,
    output logic [DATA_W-1:0] mem_ir,
    output logic [DATA_W-1:0] reg_c,
    output logic              zf,
    output logic              nf,
    output logic              cf,
    output logic              flush,
    output logic [ADDR_W-1:0] branch_target,
    output logic              d_we,
    output logic [DATA_W-1:0] d_dataout,
    operand_if.execute        ops
);

    opcode_t         ex_op, mem_op;
    logic [DATA_W:0] alu_out;
    logic            dw;

    assign ex_op  = opcode_t'(ex_ir[OP_HI:OP_LO]);
    assign mem_op = opcode_t'(mem_ir[OP_HI:OP_LO]);

    alu #(.DATA_W(DATA_W)) u_alu (.op(ex_op), .a(reg_a), .b(reg_b), .result(alu_out));

    always_comb
    begin
        case (mem_op)
            JUMP, JMPR: flush = 1'b1;
            BZ:         flush = zf;
            BNZ:        flush = !zf;
            BN:         flush = nf;
            BNN:        flush = !nf;
            BC:         flush = cf;
            BNC:        flush = !cf;
            default:    flush = 1'b0;
        endcase
    end

    assign branch_target = reg_c[ADDR_W-1:0];
    assign d_we          = dw && run;

    always_ff @(posedge clock or negedge reset)
    begin
        if (!reset)
        begin
            mem_ir    <= NOP_WORD;
            reg_c     <= '0;
            d_dataout <= '0;
            dw        <= 1'b0;
            {zf, nf, cf} <= 3'b000;
        end
        else if (run)
        begin
            mem_ir <= flush ? NOP_WORD : ex_ir;
            reg_c  <= alu_out[DATA_W-1:0];
            dw     <= !flush && (ex_op == STORE);   // Strobe while STORE is in memory
            if (ex_op == STORE)
                d_dataout <= store_data;
            if (!flush && (is_arith(ex_op) || ex_op == CMP) && ex_op != LDIH)
            begin
                zf <= (alu_out[DATA_W-1:0] == '0);
                nf <= alu_out[DATA_W-1];
            end
            if (!flush)
            begin
                case (ex_op)
                    ADD, ADDI, SUB, SUBI, CMP: cf <= alu_out[DATA_W];
                    AND, OR, XOR:              cf <= 1'b0;
                    default: ;                          // Shifts keep cf
                endcase
            end
        end
    end

    assign ops.ex_result   = alu_out[DATA_W-1:0];
    assign ops.ex_dest     = ex_ir[R1_HI:R1_LO];
    assign ops.ex_fwd      = is_arith(ex_op);
    assign ops.mem_is_load = (mem_op == LOAD);
    assign ops.mem_result  = ops.mem_is_load ? d_datain : reg_c;
    assign ops.mem_dest    = mem_ir[R1_HI:R1_LO];
    assign ops.mem_fwd     = is_arith(mem_op);

endmodule

/* verilog/writeback_stage.sv */
// Memory-stage register, register file and writeback.
// Two operand read ports for decode and a third one for the debug view.
`timescale 1ns/1ps

module writeback_stage import pcpu_pkg::*; #(
    parameter int DATA_W = 16
) (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 run,
    input  logic [DATA_W-1:0]    mem_ir,
    input  logic [DATA_W-1:0]    reg_c,
    input  logic [DATA_W-1:0]    d_datain,
    output logic                 halt_retire,
    input  logic [REG_SEL_W-1:0] dbg_sel,
    output logic [DATA_W-1:0]    dbg_data,
    operand_if.regfile           ops
);

    logic [DATA_W-1:0]    wb_ir, reg_c1;
    logic [DATA_W-1:0]    gr [2**REG_SEL_W];
    opcode_t              wb_op;
    logic [REG_SEL_W-1:0] wb_dest;

    assign wb_op   = opcode_t'(wb_ir[OP_HI:OP_LO]);
    assign wb_dest = wb_ir[R1_HI:R1_LO];

    always_ff @(posedge clock or negedge reset)
    begin
        if (!reset)
        begin
            wb_ir  <= NOP_WORD;
            reg_c1 <= '0;
            for (int i = 0; i < 2**REG_SEL_W; i++)
                gr[i] <= '0;
        end
        else if (run)
        begin
            wb_ir  <= mem_ir;
            reg_c1 <= (opcode_t'(mem_ir[OP_HI:OP_LO]) == LOAD) ? d_datain : reg_c;
            if (writes_register(wb_op) && wb_dest != '0)
                gr[wb_dest] <= reg_c1;                  // r0 stays zero
        end
    end

    assign halt_retire = (wb_op == HALT);

    assign ops.wb_result = reg_c1;
    assign ops.wb_dest   = wb_dest;
    assign ops.wb_fwd    = writes_register(wb_op);
    assign ops.rd_data_a = gr[ops.rd_sel_a];
    assign ops.rd_data_b = gr[ops.rd_sel_b];
    assign dbg_data      = gr[dbg_sel];

endmodule

/* verilog/pcpu.sv */
// Top level of the 16-bit pipelined processor.
// Wires the stages to the external memories and drives the debug output y.
`timescale 1ns/1ps

module pcpu import pcpu_pkg::*; (
    input  logic              clock,
    input  logic              reset,
    input  logic              enable,
    input  logic              start,
    input  logic [DATA_W-1:0] i_datain,
    output logic [ADDR_W-1:0] i_addr,
    input  logic [DATA_W-1:0] d_datain,
    output logic [ADDR_W-1:0] d_addr,
    output logic [DATA_W-1:0] d_dataout,
    output logic              d_we,
    input  logic [3:0]        select_y,
    output logic [DATA_W-1:0] y
);

    logic              run, flush, halt_retire;
    logic              zf, nf, cf;
    logic [ADDR_W-1:0] pc, branch_target;
    logic [DATA_W-1:0] ex_ir, mem_ir, reg_a, reg_b, reg_c, store_data, dbg_data;

    operand_if #(.DATA_W(DATA_W)) u_ops ();

    run_control u_run (.clock, .reset, .enable, .start, .halt_retire, .run);

    fetch_decode #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) u_fetch_decode (
        .clock, .reset, .run, .flush, .branch_target, .pc, .i_datain,
        .ex_ir, .reg_a, .reg_b, .store_data, .ops(u_ops.decode)
    );

    execute_stage #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) u_execute (
        .clock, .reset, .run, .ex_ir, .reg_a, .reg_b, .store_data, .d_datain,
        .mem_ir, .reg_c, .zf, .nf, .cf, .flush, .branch_target, .d_we, .d_dataout,
        .ops(u_ops.execute)
    );

    writeback_stage #(.DATA_W(DATA_W)) u_writeback (
        .clock, .reset, .run, .mem_ir, .reg_c, .d_datain, .halt_retire,
        .dbg_sel(select_y[REG_SEL_W-1:0]), .dbg_data, .ops(u_ops.regfile)
    );

    assign i_addr = pc;
    assign d_addr = reg_c[ADDR_W-1:0];                  // Address computed in execute

    // Debug view: status word, registers 1 to 7, otherwise zero
    always_comb
    begin
        y = '0;
        if (select_y == 4'd0)
        begin
            y[12]         = d_we;
            y[11]         = run;
            y[10:8]       = {zf, nf, cf};
            y[ADDR_W-1:0] = pc;
        end
        else if (select_y < 4'd8)
            y = dbg_data;
    end

endmodule

/* tests/tb_clock.sv */
// Testbench clock and reset source for the processor testbench.
// Reset goes low while reset_req is sampled high and stays low for RESET_CYCLES edges.
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 5,
    parameter int DRIVE_DELAY  = 10
) (
    input  logic reset_req,
    output logic clock,
    output logic reset
);

    int left = RESET_CYCLES;

    initial
    begin
        clock = 1'b0;
        reset = 1'b0;
    end

    always #(PERIOD / 2) clock = ~clock;

    always @(posedge clock)
    begin
        if (reset_req)
            left = RESET_CYCLES;
        else if (left > 0)
            left = left - 1;
        #(DRIVE_DELAY) reset = (left == 0);    // Driven off the edge like other inputs
    end

endmodule

/* tests/pcpu_sva.sv */
// Concurrent checks on the processor top level, attached with bind.
// Covers the store strobe, the idle program counter and the first cycle out of reset.
`timescale 1ns/1ps

module pcpu_sva #(
    parameter int ADDR_W = 8
) (
    input logic              clock,
    input logic              reset,
    input logic              run,
    input logic              d_we,
    input logic [ADDR_W-1:0] i_addr
);

    // No store strobe unless the pipeline runs
    store_only_when_running: assert property (
        @(posedge clock) disable iff (!reset) !run |-> !d_we
    ) else $error("d_we high while the processor is idle");

    idle_pc_stable: assert property (
        @(posedge clock) disable iff (!reset) (!run && !$past(run)) |-> $stable(i_addr)
    ) else $error("i_addr moved while the processor is idle");

    no_store_after_reset: assert property (
        @(posedge clock) $rose(reset) |-> !d_we
    ) else $error("d_we high in the first cycle after reset");

endmodule

/* tests/pcpu_tb.sv */
// Testbench for the pipelined processor.
// Runs each program of the test table to HALT, then checks registers, flags and memory.
`timescale 1ns/1ps

module pcpu_tb import pcpu_pkg::*; ();

    localparam int NUM_TESTS = 5;
    localparam int LIMIT     = NUM_TESTS * (64 + 12);   // Run budget plus reset per entry

    typedef struct packed {
        logic [15:0][15:0] prog;
        logic [15:0]       mem_in;     // Word at 0x10
        logic [4:0][15:0]  regs;       // r5 down to r1
        logic [2:0]        flags;      // zf, nf, cf
        logic [15:0]       mem_out;    // Word at 0x20
    } test_t;

    test_t       tests [NUM_TESTS];
    logic        clock, reset, reset_req, enable, start, d_we;
    logic [15:0] i_datain, d_datain, d_dataout, y;
    logic [7:0]  i_addr, d_addr;
    logic [3:0]  select_y;
    logic [15:0] imem [256];
    logic [15:0] dmem [256];
    int          cycles = 0;

    tb_clock u_clock (.reset_req, .clock, .reset);

    pcpu u_pcpu (.clock, .reset, .enable, .start, .i_datain, .i_addr, .d_datain,
                 .d_addr, .d_dataout, .d_we, .select_y, .y);

    bind pcpu pcpu_sva u_sva (.clock(clock), .reset(reset), .run(run), .d_we(d_we),
                              .i_addr(i_addr));

    assign i_datain = imem[i_addr];
    assign d_datain = dmem[d_addr];        // Memories answer in the same cycle

    always @(posedge clock)
    begin
        if (d_we)
            dmem[d_addr] <= d_dataout;
    end

    always @(posedge clock)
    begin
        cycles++;
        if (cycles > LIMIT)
        begin
            $display("Timeout: the processor did not halt within %0d cycles", LIMIT);
            $display("TESTS FAILED");
            $fatal(1);
        end
    end

    function automatic logic [15:0] rrr(opcode_t op, int r1, int r2, int r3);
        return {op, 3'(r1), 1'b0, 3'(r2), 1'b0, 3'(r3)};
    endfunction

    function automatic logic [15:0] rr4(opcode_t op, int r1, int r2, int imm);
        return {op, 3'(r1), 1'b0, 3'(r2), 4'(imm)};
    endfunction

    function automatic logic [15:0] ri8(opcode_t op, int r1, int imm);
        return {op, 3'(r1), 8'(imm)};
    endfunction

    function automatic logic [15:0] fill_word(logic [7:0] addr);
        return {~addr, addr};
    endfunction

    task automatic check_value(string name, logic [15:0] got, logic [15:0] exp);
        assert (got === exp)
        else
        begin
            $display("FAILED %0d ns: %s = %h, expected %h", $time, name, got, exp);
            $display("TESTS FAILED");
            $fatal(1);
        end
    endtask

    task automatic build_table();
        logic [16:0] sum;
        foreach (tests[k])
        begin
            tests[k]         = '0;
            tests[k].mem_in  = 16'($urandom);
            tests[k].mem_out = fill_word(8'h20);
        end
        // Dependent chain, every operand forwarded
        tests[0].prog[0] = ri8(LDIH, 1, 8'h12);
        tests[0].prog[1] = ri8(ADDI, 1, 8'h34);
        tests[0].prog[2] = rrr(ADD, 2, 1, 1);
        tests[0].prog[3] = rrr(SUB, 3, 2, 1);
        tests[0].prog[4] = rr4(SLL, 3, 3, 4);
        tests[0].prog[5] = rrr(AND, 4, 3, 2);
        tests[0].prog[6] = rrr(OR, 4, 4, 1);
        tests[0].prog[7] = rrr(XOR, 5, 4, 2);
        tests[0].prog[8] = rr4(SRL, 5, 5, 2);
        tests[0].prog[9] = ri8(HALT, 0, 0);
        tests[0].regs    = {16'h0587, 16'h3274, 16'h2340, 16'h2468, 16'h1234};
        // Load use right after the load, store then read back
        tests[1].prog[0] = ri8(ADDI, 2, 8'h10);
        tests[1].prog[1] = ri8(ADDI, 4, 8'h20);
        tests[1].prog[2] = rr4(LOAD, 1, 2, 0);
        tests[1].prog[3] = rrr(ADD, 3, 1, 1);
        tests[1].prog[4] = rr4(STORE, 3, 4, 0);
        tests[1].prog[5] = rr4(LOAD, 5, 4, 0);
        tests[1].prog[6] = ri8(HALT, 0, 0);
        sum = {1'b0, tests[1].mem_in} + {1'b0, tests[1].mem_in};
        tests[1].regs    = {sum[15:0], 16'h0020, sum[15:0], 16'h0010, tests[1].mem_in};
        tests[1].flags   = {sum[15:0] == 16'h0, sum[15], sum[16]};
        tests[1].mem_out = sum[15:0];
        // Taken BZ, untaken BNZ, BNN, BNC, then JUMP and JMPR
        tests[2].prog[0]  = ri8(ADDI, 1, 5);
        tests[2].prog[1]  = ri8(SUBI, 1, 5);
        tests[2].prog[2]  = ri8(BZ, 0, 6);
        tests[2].prog[3]  = ri8(ADDI, 2, 8'h11);
        tests[2].prog[4]  = ri8(ADDI, 3, 8'h22);
        tests[2].prog[5]  = ri8(ADDI, 4, 8'h33);
        tests[2].prog[6]  = ri8(BNZ, 0, 8'h0f);
        tests[2].prog[7]  = ri8(SUBI, 2, 1);
        tests[2].prog[8]  = ri8(BNN, 0, 8'h0f);
        tests[2].prog[9]  = ri8(BNC, 0, 8'h0f);
        tests[2].prog[10] = ri8(JUMP, 0, 12);
        tests[2].prog[11] = ri8(ADDI, 5, 8'h77);
        tests[2].prog[12] = ri8(ADDI, 3, 8'h0e);
        tests[2].prog[13] = ri8(JMPR, 3, 1);
        tests[2].prog[14] = ri8(ADDI, 4, 8'h44);
        tests[2].prog[15] = ri8(HALT, 0, 0);
        tests[2].regs     = {16'h0000, 16'h0000, 16'h000e, 16'hffff, 16'h0000};
        // CMP without write, BN and BC taken, shift keeps cf, logic clears it
        tests[3].prog[0] = ri8(LDIH, 1, 8'h80);
        tests[3].prog[1] = ri8(ADDI, 3, 1);
        tests[3].prog[2] = rrr(CMP, 2, 3, 1);
        tests[3].prog[3] = ri8(BN, 0, 7);
        for (int i = 4; i < 7; i++)
            tests[3].prog[i] = ri8(ADDI, 4, 8'h44);
        tests[3].prog[7] = rr4(SLL, 5, 3, 3);
        tests[3].prog[8] = ri8(BC, 0, 12);
        for (int i = 9; i < 12; i++)
            tests[3].prog[i] = ri8(ADDI, 2, 8'h55);
        tests[3].prog[12] = rrr(CMP, 2, 0, 5);
        tests[3].prog[13] = rrr(XOR, 4, 5, 3);
        tests[3].prog[14] = ri8(HALT, 0, 0);
        tests[3].regs     = {16'h0008, 16'h0009, 16'h0001, 16'h0000, 16'h8000};
        // Writes to r0 vanish, r0 reads zero even behind a load
        tests[4].prog[0] = ri8(ADDI, 0, 8'h7f);
        tests[4].prog[1] = rrr(ADD, 1, 0, 0);
        tests[4].prog[2] = ri8(ADDI, 1, 3);
        tests[4].prog[3] = rrr(ADD, 2, 1, 0);
        tests[4].prog[4] = rr4(LOAD, 0, 0, 0);
        tests[4].prog[5] = rrr(ADD, 3, 0, 2);
        tests[4].prog[6] = rrr(SUB, 4, 0, 3);
        tests[4].prog[7] = ri8(LDIH, 5, 1);
        tests[4].prog[8] = rrr(CMP, 0, 5, 5);
        tests[4].prog[9] = ri8(HALT, 0, 0);
        tests[4].regs    = {16'h0100, 16'hfffd, 16'h0003, 16'h0003, 16'h0003};
        tests[4].flags   = 3'b100;
    endtask

    task automatic run_test(int k);
        reset_req = 1'b1;
        enable    = 1'b0;
        start     = 1'b0;
        select_y  = 4'd0;
        for (int a = 0; a < 256; a++)
        begin
            imem[a] = (a < 16) ? tests[k].prog[a] : NOP_WORD;
            dmem[a] = fill_word(8'(a));
        end
        dmem[8'h10] = tests[k].mem_in;
        repeat (2) @(posedge clock);
        #10 reset_req = 1'b0;
        wait (reset == 1'b1);
        @(posedge clock);
        #10 enable = 1'b1;
        start = 1'b1;
        @(posedge clock);
        #10 start = 1'b0;
        while (y[11] == 1'b1)              // Run bit of the status word
        begin
            @(posedge clock);
            #10;
        end
        check_value("status", {11'h0, y[12:8]}, {13'h0, tests[k].flags});
        for (int r = 1; r <= 5; r++)
        begin
            select_y = 4'(r);
            #1 check_value($sformatf("test %0d r%0d", k, r), y, tests[k].regs[r - 1]);
        end
        check_value($sformatf("test %0d dmem[0x20]", k), dmem[8'h20], tests[k].mem_out);
    endtask

    initial
    begin
        reset_req = 1'b1;
        enable    = 1'b0;
        start     = 1'b0;
        select_y  = 4'd0;
        void'($urandom(32'h356b_d0d0));
        build_table();
        for (int k = 0; k < NUM_TESTS; k++)
            run_test(k);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* flist.f */
verilog/pcpu_pkg.sv
verilog/operand_if.sv
verilog/run_control.sv
verilog/fetch_decode.sv
verilog/alu.sv
verilog/execute_stage.sv
verilog/writeback_stage.sv
verilog/pcpu.sv
tests/tb_clock.sv
tests/pcpu_sva.sv
tests/pcpu_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Compile with Verilator and run; the exit status is the test result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module pcpu_tb -f flist.f -o pcpu_sim &&
./obj_dir/pcpu_sim || exit 1
